/* design/fm_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, slot identity, write requests and parameter words for the
// FM register section; modules refer to these through fm_pkg:: names
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fm_pkg;

    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;
    typedef logic [7:0]  reg_addr_t;
    // register byte, or block plus full frequency number
    typedef logic [13:0] wdata_t;

    // op is the position in slot order S1, S3, S2, S4
    typedef struct packed {
        logic [1:0] op;
        logic [2:0] ch;
    } slot_t;

    typedef enum logic [3:0] {
        fld_keyon,
        fld_dt1_mul,
        fld_tl,
        fld_ks_ar,
        fld_am_d1r,
        fld_d2r,
        fld_sl_rr,
        fld_fnum,
        fld_fb_alg,
        fld_lr_ams_pms
    } fm_field_e;

    typedef struct packed {
        fm_field_e field;
        slot_t     target;
        wdata_t    data;
        logic      commit;
    } wr_req_t;

    typedef struct packed {
        fnum_t      fnum;
        block_t     block;
        logic [2:0] fb;
        logic [2:0] alg;
        logic [1:0] rl;
        logic [1:0] ams;
        logic [2:0] pms;
    } ch_params_t;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amen;
        logic [4:0] d1r;
        logic [4:0] d2r;
        logic [3:0] sl;
        logic [3:0] rr;
    } op_params_t;

    typedef enum logic [1:0] {
        st_idle,
        st_addr_held,
        st_pending
    } dec_state_e;

endpackage

`default_nettype wire

/* design/slot_sequencer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot counter, one operator of one channel per enabled clock, chip order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module slot_sequencer #(
    parameter int NUM_CH = 6
) (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          clk_en,
    output fm_pkg::slot_t      cur,
    output logic               zero
);

    fm_pkg::slot_t nxt;

    // channel moves first, op steps when the channel wraps
    always_comb begin
        nxt = cur;
        if (NUM_CH == 3) begin
            if (cur.ch == 3'd2) begin
                nxt.ch = 3'd0;
                nxt.op = cur.op + 2'd1;
            end else begin
                nxt.ch = cur.ch + 3'd1;
            end
        end else begin
            if (cur.ch == 3'd6) begin
                nxt.ch = 3'd0;
                nxt.op = cur.op + 2'd1;
            end else if (cur.ch[1:0] == 2'd2) begin
                // code 3 is not a channel
                nxt.ch = cur.ch + 3'd2;
            end else begin
                nxt.ch = cur.ch + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cur <= '0;
        end else if (clk_en) begin
            cur <= nxt;
        end
    end

    assign zero = clk_en && (cur.op == 2'd0) && (cur.ch == 3'd0);

    // storage lines rely on the counter never landing on codes 3 or 7
    a_valid_ch: assert property (@(posedge clk) disable iff (reset)
        cur.ch[1:0] != 2'b11);

endmodule

`default_nettype wire

/* design/write_decoder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host address/data writes in, one pending slot write out; the request
// commits in the first matching slot and busy covers the wait
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module write_decoder #(
    parameter int NUM_CH = 6
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        clk_en,
    input  wire logic        wr,
    input  wire logic        a0,
    input  wire logic        part,
    input  wire logic [7:0]  din,
    input  fm_pkg::slot_t    cur,
    output fm_pkg::wr_req_t  req,
    output logic             busy
);

    fm_pkg::dec_state_e state;
    fm_pkg::reg_addr_t  addr_q;
    logic               part_q;
    // frequency latch, loaded by 0xA4..0xA6
    fm_pkg::block_t     latch_blk;
    logic [2:0]         latch_fhi;

    fm_pkg::fm_field_e  field_q, dec_field;
    fm_pkg::slot_t      target_q, dec_target;
    fm_pkg::wdata_t     data_q, dec_data;
    logic               dec_valid, dec_latch, match, commit;
    logic               addr_wr, data_wr;

    assign busy    = (state == fm_pkg::st_pending);
    assign addr_wr = wr && !a0 && !busy;
    assign data_wr = wr && a0 && (state == fm_pkg::st_addr_held);

    always_comb begin
        dec_valid  = 1'b0;
        dec_latch  = 1'b0;
        dec_field  = fm_pkg::fld_keyon;
        dec_target = '0;
        dec_data   = {6'd0, din};
        if (addr_q == 8'h28) begin
            dec_target.ch = din[2:0];
            dec_data      = {10'd0, din[7:4]};
            dec_valid     = (din[1:0] != 2'd3) && ((NUM_CH == 6) || !din[2]);
        end else if (addr_q[1:0] != 2'd3) begin
            dec_target.ch = {(NUM_CH == 6) ? part_q : 1'b0, addr_q[1:0]};
            dec_valid     = 1'b1;
            case (addr_q[7:4])
                4'h3: dec_field = fm_pkg::fld_dt1_mul;
                4'h4: dec_field = fm_pkg::fld_tl;
                4'h5: dec_field = fm_pkg::fld_ks_ar;
                4'h6: dec_field = fm_pkg::fld_am_d1r;
                4'h7: dec_field = fm_pkg::fld_d2r;
                4'h8: dec_field = fm_pkg::fld_sl_rr;
                4'ha: begin
                    dec_field = fm_pkg::fld_fnum;
                    dec_data  = {latch_blk, latch_fhi, din};
                    dec_latch = (addr_q[3:2] == 2'd1);
                    dec_valid = (addr_q[3:2] == 2'd0);
                end
                4'hb: begin
                    dec_field = (addr_q[3:2] == 2'd0) ? fm_pkg::fld_fb_alg
                                                      : fm_pkg::fld_lr_ams_pms;
                    dec_valid = !addr_q[3];
                end
                default: dec_valid = 1'b0;
            endcase
            // operator fields carry the op from address bits 3:2
            if (addr_q[7:4] < 4'ha) begin
                dec_target.op = addr_q[3:2];
            end
        end
    end

    // keyon and channel fields ignore op
    always_comb begin
        case (field_q)
            fm_pkg::fld_keyon, fm_pkg::fld_fnum,
            fm_pkg::fld_fb_alg, fm_pkg::fld_lr_ams_pms: match = (cur.ch == target_q.ch);
            default: match = (cur == target_q);
        endcase
    end

    assign commit = busy && clk_en && match;
    assign req    = '{field: field_q, target: target_q, data: data_q, commit: commit};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= fm_pkg::st_idle;
            latch_blk <= '0;
            latch_fhi <= '0;
        end else begin
            case (state)
                fm_pkg::st_idle: if (addr_wr) state <= fm_pkg::st_addr_held;
                fm_pkg::st_addr_held: if (data_wr && dec_valid) state <= fm_pkg::st_pending;
                fm_pkg::st_pending: if (commit) state <= fm_pkg::st_addr_held;
                default: state <= fm_pkg::st_idle;
            endcase
            if (data_wr && dec_latch) begin
                latch_blk <= din[5:3];
                latch_fhi <= din[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_wr) begin
            addr_q <= din;
            part_q <= part;
        end
        if (data_wr && dec_valid) begin
            field_q  <= dec_field;
            target_q <= dec_target;
            data_q   <= dec_data;
        end
    end

    // commit ends the pending wait, busy is gone a cycle later
    a_commit_pending: assert property (@(posedge clk) disable iff (reset)
        req.commit |-> busy ##1 !busy);

endmodule

`default_nettype wire

/* design/slot_shift_reg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circulating delay line for per-slot storage; feed head back to keep it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module slot_shift_reg #(
    parameter int               WIDTH     = 8,
    parameter int               STAGES    = 6,
    parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             clk_en,
    input  wire logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0]      head
);

    logic [WIDTH-1:0] line [STAGES];

    // word at din comes out at head STAGES enabled cycles later
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < STAGES; i++) begin
                line[i] <= RESET_VAL;
            end
        end else if (clk_en) begin
            line[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    assign head = line[STAGES-1];

endmodule

`default_nettype wire

/* design/channel_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-channel word: frequency, block, feedback, algorithm, panning, lfo
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module channel_regs #(
    parameter int NUM_CH = 6
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           clk_en,
    input  fm_pkg::wr_req_t     req,
    output fm_pkg::ch_params_t  ch_out
);

    // both outputs enabled out of reset
    localparam fm_pkg::ch_params_t RESET_WORD = '{
        fnum:  11'd0,
        block: 3'd0,
        fb:    3'd0,
        alg:   3'd0,
        rl:    2'b11,
        ams:   2'd0,
        pms:   3'd0
    };

    fm_pkg::ch_params_t head, merged;

    always_comb begin
        merged = head;
        if (req.commit) begin
            case (req.field)
                fm_pkg::fld_fnum: begin
                    merged.block = req.data[13:11];
                    merged.fnum  = req.data[10:0];
                end
                fm_pkg::fld_fb_alg: begin
                    merged.fb  = req.data[5:3];
                    merged.alg = req.data[2:0];
                end
                fm_pkg::fld_lr_ams_pms: begin
                    merged.rl  = req.data[7:6];
                    merged.ams = req.data[5:4];
                    merged.pms = req.data[2:0];
                end
                default: ;
            endcase
        end
    end

    slot_shift_reg #(
        .WIDTH     ($bits(fm_pkg::ch_params_t)),
        .STAGES    (NUM_CH),
        .RESET_VAL (RESET_WORD)
    ) u_line (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .din    (merged),
        .head   (head)
    );

    // three-channel parts have no stereo, panning stays on
    always_comb begin
        ch_out = head;
        if (NUM_CH == 3) begin
            ch_out.rl = 2'b11;
        end
    end

endmodule

`default_nettype wire

/* design/operator_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-operator word: detune, multiple, total level, rates and levels
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module operator_regs #(
    parameter int NUM_CH = 6
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           clk_en,
    input  fm_pkg::wr_req_t     req,
    output fm_pkg::op_params_t  op_out
);

    fm_pkg::op_params_t head, merged;
    logic [7:0]         d;

    assign d = req.data[7:0];

    // each register byte owns a fixed set of sub-fields
    always_comb begin
        merged = head;
        if (req.commit) begin
            case (req.field)
                fm_pkg::fld_dt1_mul: begin
                    merged.dt1 = d[6:4];
                    merged.mul = d[3:0];
                end
                fm_pkg::fld_tl: begin
                    merged.tl = d[6:0];
                end
                fm_pkg::fld_ks_ar: begin
                    merged.ks = d[7:6];
                    merged.ar = d[4:0];
                end
                fm_pkg::fld_am_d1r: begin
                    merged.amen = d[7];
                    merged.d1r  = d[4:0];
                end
                fm_pkg::fld_d2r: begin
                    merged.d2r = d[4:0];
                end
                fm_pkg::fld_sl_rr: begin
                    merged.sl = d[7:4];
                    merged.rr = d[3:0];
                end
                default: ;
            endcase
        end
    end

    // one word per slot, four operators per channel
    slot_shift_reg #(
        .WIDTH     ($bits(fm_pkg::op_params_t)),
        .STAGES    (4 * NUM_CH),
        .RESET_VAL ('0)
    ) u_line (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .din    (merged),
        .head   (head)
    );

    assign op_out = head;

endmodule

`default_nettype wire

/* design/keyon_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// key-on masks per channel, key-on level and rising edge per slot
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module keyon_ctrl #(
    parameter int NUM_CH = 6
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        clk_en,
    input  fm_pkg::slot_t    cur,
    input  fm_pkg::wr_req_t  req,
    output logic             keyon,
    output logic             keyon_edge
);

    logic [3:0] mask_head, mask_in;
    logic       last_head;

    assign mask_in = (req.commit && (req.field == fm_pkg::fld_keyon)) ? req.data[3:0]
                                                                      : mask_head;

    slot_shift_reg #(.WIDTH(4), .STAGES(NUM_CH), .RESET_VAL(4'd0)) u_mask (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .din    (mask_in),
        .head   (mask_head)
    );

    assign keyon = mask_head[cur.op];

    // level seen on this slot's previous visit
    slot_shift_reg #(.WIDTH(1), .STAGES(4 * NUM_CH), .RESET_VAL(1'b0)) u_last (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .din    (keyon),
        .head   (last_head)
    );

    assign keyon_edge = keyon && !last_head;

    // a key-on request carries only the four-bit operator mask
    a_mask_only: assert property (@(posedge clk) disable iff (reset)
        (req.commit && (req.field == fm_pkg::fld_keyon)) |-> (req.data[13:4] == '0));

endmodule

`default_nettype wire

/* design/fm_regs_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register section top; NUM_CH selects the six or three channel part
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fm_regs_top #(
    parameter int NUM_CH = 6
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           clk_en,
    input  wire logic           wr,
    input  wire logic           a0,
    input  wire logic           part,
    input  wire logic [7:0]     din,
    output logic                busy,
    output fm_pkg::slot_t       slot,
    output logic                zero,
    output fm_pkg::ch_params_t  ch_out,
    output fm_pkg::op_params_t  op_out,
    output logic                keyon,
    output logic                keyon_edge
);

    fm_pkg::slot_t   cur;
    fm_pkg::wr_req_t req;

    slot_sequencer #(.NUM_CH(NUM_CH)) u_seq (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .cur    (cur),
        .zero   (zero)
    );

    // only the decoder knows which slot a write targets
    write_decoder #(.NUM_CH(NUM_CH)) u_dec (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .wr     (wr),
        .a0     (a0),
        .part   (part),
        .din    (din),
        .cur    (cur),
        .req    (req),
        .busy   (busy)
    );

    channel_regs #(.NUM_CH(NUM_CH)) u_ch (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .req    (req),
        .ch_out (ch_out)
    );

    operator_regs #(.NUM_CH(NUM_CH)) u_op (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .req    (req),
        .op_out (op_out)
    );

    keyon_ctrl #(.NUM_CH(NUM_CH)) u_kon (
        .clk        (clk),
        .reset      (reset),
        .clk_en     (clk_en),
        .cur        (cur),
        .req        (req),
        .keyon      (keyon),
        .keyon_edge (keyon_edge)
    );

    assign slot = cur;

endmodule

`default_nettype wire

/* tests/fm_regs_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watches the FM register DUT, keeps a register model of every slot and
// compares each enabled slot against it; counts go back to the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fm_regs_checker (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               clk_en,
    input  wire logic               wr,
    input  wire logic               a0,
    input  wire logic               part,
    input  wire logic [7:0]         din,
    input  wire logic               busy,
    input  wire fm_pkg::slot_t      slot,
    input  wire logic               zero,
    input  wire fm_pkg::ch_params_t ch_out,
    input  wire fm_pkg::op_params_t op_out,
    input  wire logic               keyon,
    input  wire logic               keyon_edge,
    output int                      errors,
    output int                      checks
);

    // model indexed by channel code, and by op and channel code
    fm_pkg::ch_params_t ch_m [8];
    fm_pkg::op_params_t op_m [4][8];
    logic [3:0]         kon_m [8];
    logic               last_m [4][8];
    fm_pkg::slot_t      exp_slot;
    fm_pkg::wr_req_t    pend;
    logic [7:0]         addr_q;
    logic               part_q;
    logic               have_addr;
    logic [5:0]         latch;
    logic               busy_prev;
    logic               busy_due;
    logic               check_busy;
    logic               exp_kon;

    initial begin
        errors = 0;
        checks = 0;
    end

    // commit in the result marks a write that goes pending
    function automatic fm_pkg::wr_req_t decode_ref(input logic [7:0] addr,
                                                   input logic       prt,
                                                   input logic [7:0] d,
                                                   input logic [5:0] lat);
        fm_pkg::wr_req_t r;
        r = '0;
        r.target = '{op: addr[3:2], ch: {prt, addr[1:0]}};
        r.data = {6'd0, d};
        r.commit = (addr[1:0] != 2'd3);
        case (addr[7:4])
            4'h3: r.field = fm_pkg::fld_dt1_mul;
            4'h4: r.field = fm_pkg::fld_tl;
            4'h5: r.field = fm_pkg::fld_ks_ar;
            4'h6: r.field = fm_pkg::fld_am_d1r;
            4'h7: r.field = fm_pkg::fld_d2r;
            4'h8: r.field = fm_pkg::fld_sl_rr;
            default: r.commit = 1'b0;
        endcase
        if (addr >= 8'ha0 && addr <= 8'ha2) begin
            r.field = fm_pkg::fld_fnum;
            r.data = {lat, d};
            r.commit = 1'b1;
        end else if (addr >= 8'hb0 && addr <= 8'hb2) begin
            r.field = fm_pkg::fld_fb_alg;
            r.commit = 1'b1;
        end else if (addr >= 8'hb4 && addr <= 8'hb6) begin
            r.field = fm_pkg::fld_lr_ams_pms;
            r.commit = 1'b1;
        end
        // key-on carries its channel in the data byte
        if (addr == 8'h28) begin
            r.field = fm_pkg::fld_keyon;
            r.target = '{op: 2'd0, ch: d[2:0]};
            r.data = {10'd0, d[7:4]};
            r.commit = (d[1:0] != 2'd3);
        end
        return r;
    endfunction

    function automatic fm_pkg::ch_params_t merge_ch(input fm_pkg::ch_params_t p,
                                                    input fm_pkg::wr_req_t    r);
        case (r.field)
            fm_pkg::fld_fnum: begin
                p.block = r.data[13:11];
                p.fnum = r.data[10:0];
            end
            fm_pkg::fld_fb_alg: begin
                p.fb = r.data[5:3];
                p.alg = r.data[2:0];
            end
            fm_pkg::fld_lr_ams_pms: begin
                p.rl = r.data[7:6];
                p.ams = r.data[5:4];
                p.pms = r.data[2:0];
            end
            default: ;
        endcase
        return p;
    endfunction

    function automatic fm_pkg::op_params_t merge_op(input fm_pkg::op_params_t p,
                                                    input fm_pkg::wr_req_t    r);
        case (r.field)
            fm_pkg::fld_dt1_mul: begin
                p.dt1 = r.data[6:4];
                p.mul = r.data[3:0];
            end
            fm_pkg::fld_tl: p.tl = r.data[6:0];
            fm_pkg::fld_ks_ar: begin
                p.ks = r.data[7:6];
                p.ar = r.data[4:0];
            end
            fm_pkg::fld_am_d1r: begin
                p.amen = r.data[7];
                p.d1r = r.data[4:0];
            end
            fm_pkg::fld_d2r: p.d2r = r.data[4:0];
            fm_pkg::fld_sl_rr: begin
                p.sl = r.data[7:4];
                p.rr = r.data[3:0];
            end
            default: ;
        endcase
        return p;
    endfunction

    // chip order, channel first and code 3 skipped
    function automatic fm_pkg::slot_t next_slot(input fm_pkg::slot_t s);
        if (s.ch == 3'd6) begin
            s.ch = 3'd0;
            s.op = s.op + 2'd1;
        end else if (s.ch == 3'd2) begin
            s.ch = 3'd4;
        end else begin
            s.ch = s.ch + 3'd1;
        end
        return s;
    endfunction

    task automatic apply_write(input fm_pkg::wr_req_t r);
        case (r.field)
            fm_pkg::fld_keyon: kon_m[r.target.ch] = r.data[3:0];
            fm_pkg::fld_fnum, fm_pkg::fld_fb_alg, fm_pkg::fld_lr_ams_pms:
                ch_m[r.target.ch] = merge_ch(ch_m[r.target.ch], r);
            default:
                op_m[r.target.op][r.target.ch] = merge_op(op_m[r.target.op][r.target.ch], r);
        endcase
    endtask

    task automatic reset_model();
        for (int c = 0; c < 8; c++) begin
            ch_m[c] = '0;
            ch_m[c].rl = 2'b11;
            kon_m[c] = 4'd0;
            for (int o = 0; o < 4; o++) begin
                op_m[o][c] = '0;
                last_m[o][c] = 1'b0;
            end
        end
        exp_slot = '0;
        pend = '0;
        have_addr = 1'b0;
        latch = 6'd0;
        busy_prev = 1'b0;
        // busy must be low on the first cycle out of reset
        busy_due = 1'b0;
        check_busy = 1'b1;
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %0h, expected %0h (op %0d ch %0d) at %0t",
                     name, got, exp, exp_slot.op, exp_slot.ch, $time);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            if (check_busy) begin
                check_val("busy", busy, busy_due);
                check_busy = 1'b0;
            end
            // busy drops the cycle after the commit
            if (busy_prev && !busy) begin
                apply_write(pend);
            end
            if (wr && !busy) begin
                if (!a0) begin
                    addr_q = din;
                    part_q = part;
                    have_addr = 1'b1;
                end else if (have_addr) begin
                    pend = decode_ref(addr_q, part_q, din, latch);
                    if (addr_q >= 8'ha4 && addr_q <= 8'ha6) begin
                        latch = din[5:0];
                    end
                    busy_due = pend.commit;
                    check_busy = 1'b1;
                end
            end
            check_val("zero", zero, clk_en && (exp_slot == '0));
            if (clk_en) begin
                exp_kon = kon_m[exp_slot.ch][exp_slot.op];
                check_val("slot", slot, exp_slot);
                check_val("ch_out", ch_out, ch_m[exp_slot.ch]);
                check_val("op_out", op_out, op_m[exp_slot.op][exp_slot.ch]);
                check_val("keyon", keyon, exp_kon);
                check_val("keyon_edge", keyon_edge, exp_kon && !last_m[exp_slot.op][exp_slot.ch]);
                last_m[exp_slot.op][exp_slot.ch] = exp_kon;
                exp_slot = next_slot(exp_slot);
            end
            busy_prev = busy;
        end
    end

endmodule

`default_nettype wire

/* tests/fm_regs_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the FM register section; host writes, random clock enable
// and a watchdog around the DUT and its checker
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fm_regs_tb;

    localparam int NUM_CH     = 6;
    localparam int NUM_WRITES = 64;
    // each write waits at most one period of 24 slots at 3/4 enable rate
    localparam int WATCHDOG_CYCLES = 16 + 300 + NUM_WRITES * (24 * 4 / 3 + 12) + 1000;

    logic               clk;
    logic               reset;
    logic               clk_en;
    logic               wr;
    logic               a0;
    logic               part;
    logic [7:0]         din;
    logic               busy;
    fm_pkg::slot_t      slot;
    logic               zero;
    fm_pkg::ch_params_t ch_out;
    fm_pkg::op_params_t op_out;
    logic               keyon;
    logic               keyon_edge;
    int                 errors;
    int                 checks;
    int                 stuck;
    int                 num_writes;
    integer             seed = 98122;

    fm_regs_top #(.NUM_CH(NUM_CH)) UUT (
        .clk        (clk),
        .reset      (reset),
        .clk_en     (clk_en),
        .wr         (wr),
        .a0         (a0),
        .part       (part),
        .din        (din),
        .busy       (busy),
        .slot       (slot),
        .zero       (zero),
        .ch_out     (ch_out),
        .op_out     (op_out),
        .keyon      (keyon),
        .keyon_edge (keyon_edge)
    );

    fm_regs_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .clk_en     (clk_en),
        .wr         (wr),
        .a0         (a0),
        .part       (part),
        .din        (din),
        .busy       (busy),
        .slot       (slot),
        .zero       (zero),
        .ch_out     (ch_out),
        .op_out     (op_out),
        .keyon      (keyon),
        .keyon_edge (keyon_edge),
        .errors     (errors),
        .checks     (checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // about three enabled cycles in four
    always @(negedge clk) begin
        clk_en = (($random(seed) & 3) != 0);
    end

    // one-cycle strobe, a0 low for address and high for data
    task automatic bus_cycle(input logic is_data, input logic prt, input logic [7:0] val);
        @(negedge clk);
        wr = 1'b1;
        a0 = is_data;
        part = prt;
        din = val;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("busy stayed high for 200 cycles after a data write at %0t", $time);
            stuck++;
        end
    endtask

    task automatic write_reg(input logic prt, input logic [7:0] addr, input logic [7:0] val);
        bus_cycle(1'b0, prt, addr);
        bus_cycle(1'b1, prt, val);
        wait_not_busy();
        num_writes++;
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  nib;
        stuck = 0;
        num_writes = 0;
        reset = 1'b1;
        clk_en = 1'b0;
        wr = 1'b0;
        a0 = 1'b0;
        part = 1'b0;
        din = 8'd0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // reset values and slot order over a few periods
        repeat (100) @(negedge clk);

        // one slot, every operator register, other bits kept
        write_reg(1'b0, 8'h30, 8'h75);
        write_reg(1'b0, 8'h50, 8'hdf);
        write_reg(1'b0, 8'h60, 8'h9f);
        write_reg(1'b0, 8'h70, 8'h1f);
        write_reg(1'b0, 8'h80, 8'ha5);
        write_reg(1'b0, 8'h40, 8'h7f);
        // random operator writes over both parts, channel-low 3 included
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            nib = 3 + (r[7:0] % 6);
            write_reg(r[12], {nib, r[9:8], r[11:10]}, r[23:16]);
        end

        // frequency latch, then low bytes with and without a new latch
        write_reg(1'b0, 8'ha4, 8'h2d);
        write_reg(1'b0, 8'ha0, 8'h9c);
        write_reg(1'b1, 8'ha1, 8'h33);
        write_reg(1'b1, 8'ha6, 8'h17);
        write_reg(1'b1, 8'ha2, 8'he1);
        write_reg(1'b0, 8'ha1, 8'h44);
        write_reg(1'b0, 8'hb0, 8'h3b);
        write_reg(1'b1, 8'hb1, 8'h2c);
        write_reg(1'b0, 8'hb2, 8'h07);
        write_reg(1'b0, 8'hb4, 8'h87);
        write_reg(1'b1, 8'hb5, 8'h45);
        write_reg(1'b1, 8'hb6, 8'h3f);

        // unmapped addresses and channel code 3
        write_reg(1'b0, 8'h23, 8'hff);
        write_reg(1'b0, 8'h93, 8'hff);
        write_reg(1'b1, 8'hb8, 8'hff);
        write_reg(1'b0, 8'ha8, 8'hff);
        write_reg(1'b0, 8'h33, 8'hff);
        write_reg(1'b1, 8'h9c, 8'haa);
        write_reg(1'b0, 8'h28, 8'hf3);

        // key-on masks, then ops 1 and 3 of channel 0 off and on again
        write_reg(1'b0, 8'h28, 8'hf0);
        write_reg(1'b0, 8'h28, 8'h31);
        write_reg(1'b0, 8'h28, 8'hc2);
        write_reg(1'b0, 8'h28, 8'h94);
        write_reg(1'b0, 8'h28, 8'hf5);
        write_reg(1'b0, 8'h28, 8'h66);
        repeat (40) @(negedge clk);
        write_reg(1'b0, 8'h28, 8'h50);
        repeat (40) @(negedge clk);
        write_reg(1'b0, 8'h28, 8'hf0);
        write_reg(1'b0, 8'h28, 8'h04);
        write_reg(1'b0, 8'h28, 8'hf7);

        // a second pair right behind the first lands while busy
        bus_cycle(1'b0, 1'b0, 8'h41);
        bus_cycle(1'b1, 1'b0, 8'h11);
        bus_cycle(1'b0, 1'b0, 8'h45);
        bus_cycle(1'b1, 1'b0, 8'h6e);
        wait_not_busy();
        bus_cycle(1'b0, 1'b1, 8'hb0);
        bus_cycle(1'b1, 1'b1, 8'h12);
        bus_cycle(1'b1, 1'b1, 8'h3f);
        wait_not_busy();
        num_writes += 4;

        // let every slot come round with its last value
        repeat (100) @(negedge clk);
        $display("writes %0d, checks %0d, errors %0d, handshake timeouts %0d",
                 num_writes, checks, errors, stuck);
        if (errors == 0 && stuck == 0 && checks > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("watchdog expired after %0d cycles, stimulus did not finish", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/fm_pkg.sv
design/slot_sequencer.sv
design/write_decoder.sv
design/slot_shift_reg.sv
design/channel_regs.sv
design/operator_regs.sv
design/keyon_ctrl.sv
design/fm_regs_top.sv
tests/fm_regs_checker.sv
tests/fm_regs_tb.sv
